/* bench/ucode_ctrl_tests.svh */
`ifndef UCODE_CTRL_TESTS_SVH
`define UCODE_CTRL_TESTS_SVH

// expected rows of each non-indexed routine
task automatic queue_rows(input logic [7:0] op_val);
    case (op_val)
        `OP_LDA_IMM: begin
            exp_q.push_back(M_OPD);
            exp_q.push_back(M_LDA);
        end
        `OP_LDD_IMM: begin
            exp_q.push_back(M_OPD | M_MEMHI);  // high byte first
            exp_q.push_back(M_OPD);
            exp_q.push_back(M_LD16);
        end
        `OP_CLRA: exp_q.push_back(M_LDA);
        `OP_CMPA_IMM: begin
            exp_q.push_back(M_OPD);
            exp_q.push_back(32'd0);
        end
        `OP_BRA: begin
            exp_q.push_back(M_OPD);
            exp_q.push_back(M_BR8);
        end
        `OP_LBRA: begin
            exp_q.push_back(M_OPD | M_MEMHI);
            exp_q.push_back(M_OPD);
            exp_q.push_back(M_BR16);
        end
        `OP_JMP: exp_q.push_back(M_JMP);
        default: exp_q.push_back(32'd0);
    endcase
endtask

// from a last row to the last row of the new routine
task automatic run_rows(input logic [7:0] op_val, input bit stall);
    int i;
    int n;
    op = op_val;
    for (i = 0; i < exp_q.size(); i++) begin
        tick();
        check_val("strobes", strobes(), exp_q[i]);
        if (stall && i < exp_q.size() - 1) begin
            n = $urandom_range(1, 5);
            if ($urandom_range(0, 3) == 0) begin
                cen = 1'b0;  // clock enable low freezes too
            end else begin
                mem_busy = 1'b1;
            end
            repeat (n) begin
                tick();
                check_val("strobes held", strobes(), exp_q[i]);
            end
            cen      = 1'b1;
            mem_busy = 1'b0;
        end
    end
    op = `OP_NOP;
    exp_q.delete();
endtask

task automatic reset_start();
    apply_reset();
    check_val("strobes", strobes(), M_SETI | M_SETF);
    check_val("intvec", 32'(intvec), 32'd0);
    op = `OP_JMP;
    tick();
    check_val("strobes", strobes(), 32'd0);
    check_val("intvec", 32'(intvec), 32'd0);
    tick();  // jump started, so the previous row ended the routine
    check_val("strobes", strobes(), M_JMP);
    op = `OP_NOP;
endtask

task automatic imm_routines();
    logic [7:0] picks[$];
    logic [7:0] op_val;
    int k;
    picks = '{`OP_LDA_IMM, `OP_LDD_IMM, `OP_CLRA, `OP_BRA, `OP_LBRA, `OP_JMP};
    for (k = 0; k < 12; k++) begin
        op_val = picks[$urandom_range(0, picks.size() - 1)];
        queue_rows(op_val);
        run_rows(op_val, 1'b0);
    end
endtask

task automatic stalled_routines();
    logic [7:0] picks[$];
    logic [7:0] op_val;
    int k;
    picks = '{`OP_LDA_IMM, `OP_LDD_IMM, `OP_CMPA_IMM, `OP_BRA, `OP_LBRA};
    for (k = 0; k < 8; k++) begin
        op_val = picks[$urandom_range(0, picks.size() - 1)];
        queue_rows(op_val);
        run_rows(op_val, 1'b1);
    end
endtask

task automatic indexed_loads();
    logic [7:0]  bases[$];
    logic [7:0]  ops[$];
    logic [7:0]  pb;
    logic [2:0]  reg_sel;
    logic [31:0] row0;
    logic        post_mode;
    logic        dp_mode;
    logic        ext_mode;
    int k;
    // postbyte of every mode with the register field clear
    bases = '{8'h00, 8'h02, 8'h04, 8'h05, 8'h06, 8'h07, 8'h84, 8'h80, 8'h81, 8'h87};
    ops   = '{`OP_LDA_IDX, `OP_ADDA_IDX, `OP_LDX_IDX, `OP_STA};
    for (k = 0; k < bases.size(); k++) begin
        reg_sel   = 3'($urandom_range(0, 7));
        pb        = bases[k] | {1'b0, reg_sel, 4'h0};
        post_mode = !pb[7] && (pb[2:0] == 3'b000 || pb[2:0] == 3'b010);
        dp_mode   = pb[7] && pb[2:0] == 3'b100;
        ext_mode  = !pb[7] && pb[2:0] == 3'b111;
        row0      = post_mode ? M_IDXPOST : (M_OPD | (dp_mode ? M_IDXDP : 32'd0));
        op        = ops[k % ops.size()];
        mdata     = {8'h00, pb};
        tick();
        check_val("strobes", strobes(), M_OPD);  // postbyte fetch
        tick();
        check_val("strobes", strobes(), 32'd0);
        tick();
        check_val("strobes", strobes(), row0);
        check_val("idx_rsel", 32'(idx_rsel), 32'(reg_sel));
        check_val("idx_asel", 32'(idx_asel), 32'(pb[1:0]));
        tick();
        check_val("strobes", strobes(), 32'd0);
        check_val("idx_ld", 32'(idx_ld), 32'd0);
        tick();  // back in the follow-up routine
        check_val("idx_ld", 32'(idx_ld), 32'(!dp_mode && !ext_mode));
        check_val("idx_post", 32'(idx_post), 32'(post_mode));
        if (op == `OP_STA) begin
            check_val("strobes", strobes(), M_WE);  // store ends in one row
        end else begin
            check_val("strobes", strobes(), M_OPD);
            tick();
            check_val("strobes", strobes(), M_LDA);
            check_val("idx_ld", 32'(idx_ld), 32'd0);
            check_val("idx_post", 32'(idx_post), 32'd0);
        end
        op = `OP_NOP;
    end
endtask

task automatic interrupt_priority();
    logic [2:0]  lines;  // nmi, firq, irq asserted
    logic [3:0]  exp_vec;
    logic [31:0] row1;
    int k;
    for (k = 1; k < 8; k++) begin
        lines = 3'(k);
        if (lines[2]) begin
            exp_vec = 4'b0100;
            row1    = M_PSHALL;
        end else if (lines[1]) begin
            exp_vec = 4'b0010;
            row1    = M_PSHCC;  // fast interrupt stacks cc only
        end else begin
            exp_vec = 4'b0001;
            row1    = M_PSHALL;
        end
        nmi_n  = !lines[2];
        firq_n = !lines[1];
        irq_n  = !lines[0];
        tick();
        check_val("strobes", strobes(), M_PSHPC | M_INTEN);
        check_val("intvec", 32'(intvec), 32'(exp_vec));
        nmi_n  = 1'b1;
        firq_n = 1'b1;
        irq_n  = 1'b1;
        tick();
        check_val("strobes", strobes(), row1);
        check_val("intvec", 32'(intvec), 32'd0);
        tick();
        check_val("strobes", strobes(), M_SETI);
        check_val("intvec", 32'(intvec), 32'd0);
    end
endtask

function automatic bit legal_op(input logic [7:0] v);
    case (v)
        `OP_NOP, `OP_LDA_IMM, `OP_ADDA_IMM, `OP_LDB_IMM, `OP_LDD_IMM, `OP_CLRA,
        `OP_INCA, `OP_CMPA_IMM, `OP_BRA, `OP_BEQ, `OP_LBRA, `OP_JMP, `OP_STA,
        `OP_LDA_IDX, `OP_ADDA_IDX, `OP_LDX_IDX: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

task automatic buserror_halt();
    logic [7:0] bad;
    bad = 8'($urandom_range(0, 255));
    while (legal_op(bad)) begin
        bad = 8'($urandom_range(0, 255));
    end
    op = bad;
    tick();
    check_val("strobes", strobes(), M_BUSERR);
    op    = `OP_NOP;
    nmi_n = 1'b0;  // even nmi cannot leave the halt
    repeat (10) begin
        tick();
        check_val("strobes", strobes(), M_BUSERR);
    end
    nmi_n = 1'b1;
    apply_reset();
    check_val("strobes", strobes(), M_SETI | M_SETF);
    tick();
    check_val("strobes", strobes(), 32'd0);
endtask

`endif

/* bench/ucode_ctrl_tb.sv */
`timescale 1ns/1ns
`include "ucode_consts.svh"

module ucode_ctrl_tb;

    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 200;

    // strobe masks in the bit order of strobes()
    localparam logic [31:0] M_OPD     = 32'h40000;
    localparam logic [31:0] M_LDA     = 32'h20000;
    localparam logic [31:0] M_LD16    = 32'h08000;
    localparam logic [31:0] M_BR8     = 32'h04000;
    localparam logic [31:0] M_BR16    = 32'h02000;
    localparam logic [31:0] M_JMP     = 32'h01000;
    localparam logic [31:0] M_WE      = 32'h00800;
    localparam logic [31:0] M_MEMHI   = 32'h00400;
    localparam logic [31:0] M_PSHPC   = 32'h00200;
    localparam logic [31:0] M_PSHCC   = 32'h00100;
    localparam logic [31:0] M_PSHALL  = 32'h00080;
    localparam logic [31:0] M_SETI    = 32'h00040;
    localparam logic [31:0] M_SETF    = 32'h00020;
    localparam logic [31:0] M_INTEN   = 32'h00010;
    localparam logic [31:0] M_BUSERR  = 32'h00008;
    localparam logic [31:0] M_IDXPOST = 32'h00004;
    localparam logic [31:0] M_IDXDP   = 32'h00001;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  op;
    logic [15:0] mdata;
    logic        mem_busy;
    logic        irq_n;
    logic        nmi_n;
    logic        firq_n;
    logic        opd;
    logic        up_lda;
    logic        up_ldb;
    logic        up_ld16;
    logic        set_pc_branch8;
    logic        set_pc_branch16;
    logic        set_pc_jmp;
    logic        we;
    logic        memhi;
    logic        psh_pc;
    logic        psh_cc;
    logic        psh_all;
    logic        set_i;
    logic        set_f;
    logic        int_en;
    logic        buserror;
    logic        set_idx_post;
    logic        set_idxw;
    logic        idx_dp;
    logic [2:0]  idx_rsel;
    logic [1:0]  idx_asel;
    logic        idx_ld;
    logic        idx_post;
    logic [3:0]  intvec;

    logic [31:0] exp_q[$];  // expected strobes per row

    ucode_ctrl dut_i (
        .clk             (clk),
        .rst             (rst),
        .cen             (cen),
        .op              (op),
        .mdata           (mdata),
        .mem_busy        (mem_busy),
        .irq_n           (irq_n),
        .nmi_n           (nmi_n),
        .firq_n          (firq_n),
        .opd             (opd),
        .up_lda          (up_lda),
        .up_ldb          (up_ldb),
        .up_ld16         (up_ld16),
        .set_pc_branch8  (set_pc_branch8),
        .set_pc_branch16 (set_pc_branch16),
        .set_pc_jmp      (set_pc_jmp),
        .we              (we),
        .memhi           (memhi),
        .psh_pc          (psh_pc),
        .psh_cc          (psh_cc),
        .psh_all         (psh_all),
        .set_i           (set_i),
        .set_f           (set_f),
        .int_en          (int_en),
        .buserror        (buserror),
        .set_idx_post    (set_idx_post),
        .set_idxw        (set_idxw),
        .idx_dp          (idx_dp),
        .idx_rsel        (idx_rsel),
        .idx_asel        (idx_asel),
        .idx_ld          (idx_ld),
        .idx_post        (idx_post),
        .intvec          (intvec)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (N_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("TIMEOUT: tests did not finish within %0d cycles", N_TESTS * CYCLES_PER_TEST);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] strobes();
        return {13'd0, opd, up_lda, up_ldb, up_ld16, set_pc_branch8, set_pc_branch16,
                set_pc_jmp, we, memhi, psh_pc, psh_cc, psh_all, set_i, set_f, int_en,
                buserror, set_idx_post, set_idxw, idx_dp};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "value check failed");
        end
    endtask

    // one accepted edge and back to the falling edge
    task automatic tick();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    `include "ucode_ctrl_tests.svh"

    initial begin
        void'($urandom(32'h70fd543f));
        rst      = 1'b1;
        cen      = 1'b1;
        op       = `OP_NOP;
        mdata    = 16'h0000;
        mem_busy = 1'b0;
        irq_n    = 1'b1;
        nmi_n    = 1'b1;
        firq_n   = 1'b1;
        reset_start();
        imm_routines();
        stalled_routines();
        indexed_loads();
        interrupt_priority();
        buserror_halt();
        $display("Regression passed");
        $finish;
    end

endmodule

/* hdl/idx_postbyte_decoder.sv */
`timescale 1ns/1ns

module idx_postbyte_decoder (
    input  logic [15:0]       mdata,
    output ucode_pkg::opcat_e idx_cat,
    output logic [2:0]        rsel,
    output logic [1:0]        asel,
    output logic              ind
);

    // postbyte sits in the low byte
    assign rsel = mdata[6:4];
    assign asel = mdata[1:0];
    assign ind  = mdata[3];

    always_comb begin
        case ({mdata[7], mdata[2:0]})
            4'b0_000: idx_cat = ucode_pkg::IDX_RINC;
            4'b0_010: idx_cat = ucode_pkg::IDX_RDEC;
            4'b0_100: idx_cat = ucode_pkg::IDX_OFFSET8;
            4'b0_101: idx_cat = ucode_pkg::IDX_OFFSET16;
            4'b0_110: idx_cat = ucode_pkg::IDX_IND;
            4'b0_111: idx_cat = ucode_pkg::IDX_EXT;
            4'b1_100: idx_cat = ucode_pkg::IDX_DP;
            4'b1_000,
            4'b1_001,
            4'b1_111: idx_cat = ucode_pkg::IDX_ACC;  // accumulator offsets
            default:  idx_cat = ucode_pkg::BUSERROR;
        endcase
    end

endmodule

/* hdl/opcode_classifier.sv */
`timescale 1ns/1ns
`include "ucode_consts.svh"

module opcode_classifier (
    input  logic [7:0]        op,
    input  ucode_pkg::opcat_e post_idx,
    output ucode_pkg::opcat_e opcat,
    output ucode_pkg::opcat_e nx_cat
);

    always_comb begin
        nx_cat = post_idx;  // keep the return category unless indexed
        case (op)
            `OP_LDA_IMM,
            `OP_LDB_IMM,
            `OP_ADDA_IMM: opcat = ucode_pkg::SINGLE_ALU;

            `OP_LDD_IMM: opcat = ucode_pkg::SINGLE_ALU_16;

            `OP_CLRA,
            `OP_INCA: opcat = ucode_pkg::SINGLE_A_INH;

            `OP_CMPA_IMM: opcat = ucode_pkg::CMP8;

            `OP_BRA,
            `OP_BEQ: opcat = ucode_pkg::SBRANCH;

            `OP_LBRA: opcat = ucode_pkg::LBRANCH;
            `OP_JMP: opcat = ucode_pkg::JUMP;
            `OP_NOP: opcat = ucode_pkg::NOPE;

            // operand through the postbyte
            `OP_LDA_IDX,
            `OP_ADDA_IDX,
            `OP_LDX_IDX: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::SINGLE_ALU_IDX;
            end

            `OP_STA: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::STORE8;
            end

            default: opcat = ucode_pkg::BUSERROR;  // undefined opcode
        endcase
    end

endmodule

/* hdl/ucode_consts.svh */
`ifndef UCODE_CONSTS_SVH
`define UCODE_CONSTS_SVH

`define UCODE_AW 9   // microcode address width
`define OPCAT_AW 5   // category field of the address
`define OPLEN_W  4   // row within a routine, 16 rows max
`define UCODE_DW 24  // microcode word width

// opcodes kept from the konami-6809 map
`define OP_LDA_IMM  8'h10
`define OP_LDB_IMM  8'h11
`define OP_LDA_IDX  8'h12
`define OP_ADDA_IMM 8'h14
`define OP_ADDA_IDX 8'h16
`define OP_CMPA_IMM 8'h2c
`define OP_STA      8'h3a
`define OP_LDD_IMM  8'h40
`define OP_LDX_IDX  8'h45
`define OP_BRA      8'h60
`define OP_BEQ      8'h67
`define OP_LBRA     8'h70
`define OP_CLRA     8'h88
`define OP_JMP      8'h8a
`define OP_INCA     8'h98
`define OP_NOP      8'h3f

`endif

/* hdl/ucode_ctrl.sv */
`timescale 1ns/1ns
`include "ucode_consts.svh"

module ucode_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  op,
    input  logic [15:0] mdata,
    input  logic        mem_busy,
    input  logic        irq_n,
    input  logic        nmi_n,
    input  logic        firq_n,
    output logic        opd,
    output logic        up_lda,
    output logic        up_ldb,
    output logic        up_ld16,
    output logic        set_pc_branch8,
    output logic        set_pc_branch16,
    output logic        set_pc_jmp,
    output logic        we,
    output logic        memhi,
    output logic        psh_pc,
    output logic        psh_cc,
    output logic        psh_all,
    output logic        set_i,
    output logic        set_f,
    output logic        int_en,
    output logic        buserror,
    output logic        set_idx_post,
    output logic        set_idxw,
    output logic        idx_dp,
    output logic [2:0]  idx_rsel,
    output logic [1:0]  idx_asel,
    output logic        idx_ld,
    output logic        idx_post,
    output logic [3:0]  intvec
);

    ucode_pkg::opcat_e     opcat;
    ucode_pkg::opcat_e     nx_cat;
    ucode_pkg::opcat_e     post_idx;
    ucode_pkg::opcat_e     idx_cat;
    logic [2:0]            rsel;
    logic [1:0]            asel;
    logic                  ind;
    logic [`UCODE_AW-1:0]  addr;
    ucode_pkg::ucode_word_t word;

    opcode_classifier classifier_i (
        .op       (op),
        .post_idx (post_idx),
        .opcat    (opcat),
        .nx_cat   (nx_cat)
    );

    idx_postbyte_decoder postbyte_i (
        .mdata   (mdata),
        .idx_cat (idx_cat),
        .rsel    (rsel),
        .asel    (asel),
        .ind     (ind)
    );

    ucode_rom rom_i (
        .addr (addr),
        .word (word)
    );

    ucode_sequencer seq_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .mem_busy (mem_busy),
        .irq_n    (irq_n),
        .nmi_n    (nmi_n),
        .firq_n   (firq_n),
        .opcat    (opcat),
        .nx_cat   (nx_cat),
        .idx_cat  (idx_cat),
        .rsel     (rsel),
        .asel     (asel),
        .ind      (ind),
        .word     (word),
        .addr     (addr),
        .post_idx (post_idx),
        .idx_rsel (idx_rsel),
        .idx_asel (idx_asel),
        .idx_ld   (idx_ld),
        .idx_post (idx_post),
        .intvec   (intvec)
    );

    // datapath strobes straight from the current row
    assign opd             = word.opd;
    assign up_lda          = word.up_lda;
    assign up_ldb          = word.up_ldb;
    assign up_ld16         = word.up_ld16;
    assign set_pc_branch8  = word.set_pc_branch8;
    assign set_pc_branch16 = word.set_pc_branch16;
    assign set_pc_jmp      = word.set_pc_jmp;
    assign we              = word.we;
    assign memhi           = word.memhi;
    assign psh_pc          = word.psh_pc;
    assign psh_cc          = word.psh_cc;
    assign psh_all         = word.psh_all;
    assign set_i           = word.set_i;
    assign set_f           = word.set_f;
    assign int_en          = word.int_en;
    assign buserror        = word.buserror;
    assign set_idx_post    = word.set_idx_post;
    assign set_idxw        = word.set_idxw;
    assign idx_dp          = word.idx_dp;

endmodule

/* hdl/ucode_pkg.sv */
`include "ucode_consts.svh"

package ucode_pkg;

    // microcode categories, one routine each
    typedef enum logic [`OPCAT_AW-1:0] {
        RESET = 0,
        NMI,
        FIRQ,
        IRQ,
        BUSERROR,
        NOPE,
        SINGLE_ALU,       // 8-bit immediate alu
        SINGLE_ALU_16,    // 16-bit immediate load
        SINGLE_A_INH,
        CMP8,
        SBRANCH,
        LBRANCH,
        JUMP,
        PARSE_IDX,        // fetch postbyte, then jump to a mode
        IDX_RINC,
        IDX_RDEC,
        IDX_OFFSET8,
        IDX_OFFSET16,
        IDX_EXT,
        IDX_IND,
        IDX_DP,
        IDX_ACC,
        STORE8,
        SINGLE_ALU_IDX
    } opcat_e;

    // one microcode row, sequencing bits first
    typedef struct packed {
        logic ni;              // last row of the routine
        logic jmp_idx;         // go to the postbyte mode routine
        logic idx_ind;         // indirect check, then return
        logic idx_ret;         // return to latched category
        logic skip_noind;
        logic opd;             // fetch operand byte
        logic up_lda;
        logic up_ldb;
        logic up_ld16;
        logic set_pc_branch8;
        logic set_pc_branch16;
        logic set_pc_jmp;
        logic we;
        logic memhi;           // high byte of a 16-bit access
        logic psh_pc;
        logic psh_cc;
        logic psh_all;
        logic set_i;
        logic set_f;
        logic int_en;          // gates intvec out
        logic buserror;
        logic set_idx_post;
        logic set_idxw;
        logic idx_dp;
    } ucode_word_t;

endpackage

/* hdl/ucode_rom.sv */
`timescale 1ns/1ns
`include "ucode_consts.svh"

module ucode_rom (
    input  logic [`UCODE_AW-1:0] addr,
    output ucode_pkg::ucode_word_t word
);

    ucode_pkg::opcat_e   cat;
    logic [`OPLEN_W-1:0] row;

    assign cat = ucode_pkg::opcat_e'(addr[`UCODE_AW-1:`OPLEN_W]);
    assign row = addr[`OPLEN_W-1:0];

    always_comb begin
        word = ucode_pkg::ucode_word_t'(`UCODE_DW'(0));  // unlisted rows stay zero
        case (cat)
            ucode_pkg::RESET: begin
                case (row)
                    4'd0: begin
                        word.set_i = 1'b1;
                        word.set_f = 1'b1;
                    end
                    4'd1: word.ni = 1'b1;
                    default: ;
                endcase
            end
            ucode_pkg::NMI, ucode_pkg::FIRQ, ucode_pkg::IRQ: begin
                case (row)
                    4'd0: begin
                        word.psh_pc = 1'b1;
                        word.int_en = 1'b1;
                    end
                    4'd1: begin
                        // firq only stacks cc
                        word.psh_cc  = cat == ucode_pkg::FIRQ;
                        word.psh_all = cat != ucode_pkg::FIRQ;
                    end
                    4'd2: begin
                        word.set_i = 1'b1;
                        word.ni    = 1'b1;
                    end
                    default: ;
                endcase
            end
            ucode_pkg::NOPE: word.ni = row == 4'd0;
            ucode_pkg::SINGLE_ALU, ucode_pkg::SINGLE_ALU_IDX: begin
                word.opd    = row == 4'd0;
                word.up_lda = row == 4'd1;
                word.ni     = row == 4'd1;
            end
            ucode_pkg::SINGLE_ALU_16: begin
                word.opd     = row == 4'd0 || row == 4'd1;
                word.memhi   = row == 4'd0;  // high byte first
                word.up_ld16 = row == 4'd2;
                word.ni      = row == 4'd2;
            end
            ucode_pkg::SINGLE_A_INH: begin
                word.up_lda = row == 4'd0;
                word.ni     = row == 4'd0;
            end
            ucode_pkg::CMP8: begin
                word.opd = row == 4'd0;
                word.ni  = row == 4'd1;  // flags only, no write back
            end
            ucode_pkg::SBRANCH: begin
                word.opd            = row == 4'd0;
                word.set_pc_branch8 = row == 4'd1;
                word.ni             = row == 4'd1;
            end
            ucode_pkg::LBRANCH: begin
                word.opd             = row == 4'd0 || row == 4'd1;
                word.memhi           = row == 4'd0;
                word.set_pc_branch16 = row == 4'd2;
                word.ni              = row == 4'd2;
            end
            ucode_pkg::JUMP: begin
                word.set_pc_jmp = row == 4'd0;
                word.ni         = row == 4'd0;
            end
            ucode_pkg::PARSE_IDX: begin
                word.opd     = row == 4'd0;  // postbyte
                word.jmp_idx = row == 4'd1;
            end
            ucode_pkg::IDX_RINC, ucode_pkg::IDX_RDEC: begin
                word.set_idx_post = row == 4'd0;
                word.idx_ret      = row == 4'd1;
            end
            ucode_pkg::IDX_OFFSET8, ucode_pkg::IDX_OFFSET16, ucode_pkg::IDX_EXT,
            ucode_pkg::IDX_IND, ucode_pkg::IDX_DP, ucode_pkg::IDX_ACC: begin
                word.opd     = row == 4'd0;
                word.idx_dp  = row == 4'd0 && cat == ucode_pkg::IDX_DP;
                word.idx_ind = row == 4'd1;
            end
            ucode_pkg::STORE8: begin
                word.we = row == 4'd0;
                word.ni = row == 4'd0;
            end
            ucode_pkg::BUSERROR: word.buserror = row == 4'd0;
            default: ;
        endcase
    end

endmodule

/* hdl/ucode_sequencer.sv */
`timescale 1ns/1ns
`include "ucode_consts.svh"

module ucode_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic [7:0]            op,
    input  logic                  mem_busy,
    input  logic                  irq_n,
    input  logic                  nmi_n,
    input  logic                  firq_n,
    input  ucode_pkg::opcat_e     opcat,
    input  ucode_pkg::opcat_e     nx_cat,
    input  ucode_pkg::opcat_e     idx_cat,
    input  logic [2:0]            rsel,
    input  logic [1:0]            asel,
    input  logic                  ind,
    input  ucode_pkg::ucode_word_t word,
    output logic [`UCODE_AW-1:0]  addr,
    output ucode_pkg::opcat_e     post_idx,
    output logic [2:0]            idx_rsel,
    output logic [1:0]            idx_asel,
    output logic                  idx_ld,
    output logic                  idx_post,
    output logic [3:0]            intvec
);

    localparam logic [`OPLEN_W-1:0] ROW0 = '0;

    logic [3:0]          cur_int;
    ucode_pkg::opcat_e   idx_mode;  // mode taken at the postbyte jump
    logic                ind_rq;
    logic                advance;
    logic                take_idx;
    logic                mode_ld;
    logic                mode_post;
    logic [`UCODE_AW-1:0] step;

    assign advance   = !mem_busy && !word.buserror;  // bus error freezes addr
    assign take_idx  = cen && advance && !word.ni && word.jmp_idx;
    assign step      = (word.skip_noind && !op[4]) ? `UCODE_AW'(2) : `UCODE_AW'(1);
    assign mode_ld   = idx_mode != ucode_pkg::IDX_DP && idx_mode != ucode_pkg::IDX_EXT;
    assign mode_post = idx_mode == ucode_pkg::IDX_RINC || idx_mode == ucode_pkg::IDX_RDEC;
    assign intvec    = cur_int & {4{word.int_en}};

    always_ff @(posedge clk) begin
        if (rst) begin
            addr     <= {ucode_pkg::RESET, ROW0};
            cur_int  <= 4'b1000;
            post_idx <= ucode_pkg::RESET;
            idx_mode <= ucode_pkg::RESET;
            ind_rq   <= 1'b0;
            idx_ld   <= 1'b0;
            idx_post <= 1'b0;
        end else if (cen) begin
            idx_ld   <= 1'b0;  // single cycle pulses
            idx_post <= 1'b0;
            if (advance) begin
                if (word.ni) begin
                    // instruction boundary, nmi > firq > irq
                    if (!nmi_n) begin
                        cur_int <= 4'b0100;
                        addr    <= {ucode_pkg::NMI, ROW0};
                    end else if (!firq_n) begin
                        cur_int <= 4'b0010;
                        addr    <= {ucode_pkg::FIRQ, ROW0};
                    end else if (!irq_n) begin
                        cur_int <= 4'b0001;
                        addr    <= {ucode_pkg::IRQ, ROW0};
                    end else begin
                        cur_int <= 4'b0000;
                        addr    <= {opcat, ROW0};
                    end
                end else if (word.jmp_idx) begin
                    addr     <= {idx_cat, ROW0};
                    idx_mode <= idx_cat;
                    ind_rq   <= ind;
                    post_idx <= nx_cat;  // where to go once the address is built
                end else if (word.idx_ind) begin
                    idx_ld   <= mode_ld;
                    idx_post <= mode_post;
                    if (ind_rq) begin
                        ind_rq <= 1'b0;  // one level of indirection only
                        addr   <= {ucode_pkg::IDX_IND, ROW0};
                    end else begin
                        addr <= {post_idx, ROW0};
                    end
                end else if (word.idx_ret) begin
                    idx_ld   <= mode_ld;
                    idx_post <= mode_post;
                    ind_rq   <= 1'b0;
                    addr     <= {post_idx, ROW0};
                end else begin
                    addr <= addr + step;
                end
            end
        end
    end

    // register and accumulator fields of the postbyte
    always_ff @(posedge clk) begin
        if (take_idx) begin
            idx_rsel <= rsel;
            idx_asel <= asel;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module ucode_ctrl_tb -f vlog.f -o ucode_ctrl_sim &&
./obj_dir/ucode_ctrl_sim ||
{
    echo "simulation did not complete successfully"
    exit 1
}

/* vlog.f */
+incdir+hdl
+incdir+bench
hdl/ucode_pkg.sv
hdl/opcode_classifier.sv
hdl/idx_postbyte_decoder.sv
hdl/ucode_rom.sv
hdl/ucode_sequencer.sv
hdl/ucode_ctrl.sv
bench/ucode_ctrl_tb.sv
